/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = decode_stage_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+100
PASS_MSG  = Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation FAILED, see $(LOG)"; exit 1)
	@echo "simulation PASSED"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
hw/riscv_pkg.sv
hw/ctrl_if.sv
hw/main_decoder.sv
hw/alu_decoder.sv
hw/control_unit.sv
hw/imm_extend.sv
hw/reg_file.sv
hw/decode_stage.sv
sim/decode_stage_asserts.sv
sim/decode_stage_tb.sv

/* hw/alu_decoder.sv */
`timescale 1ns/1ps

module alu_decoder (
    input  logic   opcode_5,  // set for r-type
    input  logic   funct7_5,  // sub and sra select
    ctrl_if.alu_mp ctrl
);
    import riscv_pkg::*;

    always_comb begin
        case (ctrl.alu_op)
            aluop_add:    ctrl.alu_ctrl = alu_add;
            aluop_branch: ctrl.alu_ctrl = alu_sub;     // compare operands
            aluop_lui:    ctrl.alu_ctrl = alu_pass_b;
            aluop_rtype, aluop_itype: begin
                case (ctrl.funct3)
                    3'b000: begin
                        // addi has no sub form so opcode_5 is needed too
                        if (opcode_5 && funct7_5) begin
                            ctrl.alu_ctrl = alu_sub;
                        end else begin
                            ctrl.alu_ctrl = alu_add;
                        end
                    end
                    3'b001: ctrl.alu_ctrl = alu_sll;
                    3'b010: ctrl.alu_ctrl = alu_slt;
                    3'b011: ctrl.alu_ctrl = alu_sltu;
                    3'b100: ctrl.alu_ctrl = alu_xor;
                    3'b101: ctrl.alu_ctrl = funct7_5 ? alu_sra : alu_srl;  // srai shares bit 30
                    3'b110: ctrl.alu_ctrl = alu_or;
                    default: ctrl.alu_ctrl = alu_and;  // 3'b111
                endcase
            end
            default: ctrl.alu_ctrl = alu_add;
        endcase
    end

    assign ctrl.mul_ctrl = mul_ctrl_e'(ctrl.funct3[1:0]);  // mul flavour
    assign ctrl.div_ctrl = div_ctrl_e'(ctrl.funct3[1:0]);  // div or rem flavour

endmodule

/* hw/control_unit.sv */
`timescale 1ns/1ps

module control_unit (
    input  logic [riscv_pkg::xlen-1:0] ins,  // instruction being decoded
    ctrl_if                            ctrl  // decoded control bundle
);
    import riscv_pkg::*;

    opcode_e    opcode;
    logic [6:0] funct7;

    assign opcode      = opcode_e'(ins[6:0]);  // unlisted codes fall to default
    assign funct7      = ins[31:25];
    assign ctrl.funct3 = ins[14:12];           // shared by both decoders

    main_decoder u_main_dec (
        .opcode (opcode),
        .funct7 (funct7),
        .ctrl   (ctrl.main_mp)
    );

    alu_decoder u_alu_dec (
        .opcode_5 (ins[5]),     // opcode bit 5
        .funct7_5 (funct7[5]),
        .ctrl     (ctrl.alu_mp)
    );

endmodule

/* hw/ctrl_if.sv */
`timescale 1ns/1ps

interface ctrl_if;
    import riscv_pkg::*;

    logic        jump;        // jal or jalr
    logic        branch;      // conditional branch
    result_src_e result_src;  // writeback source
    logic        mem_write;   // store enable
    logic        alu_src;     // operand b from immediate
    imm_src_e    imm_src;     // immediate format
    logic        reg_write;   // rd write enable
    logic        op1_pc;      // operand a from pc
    logic        jalr;        // register indirect jump
    logic        rs1_used;    // for the hazard unit
    logic        rs2_used;
    logic        mul_en;
    logic        div_en;
    alu_op_e     alu_op;      // class handed to the alu decoder
    alu_ctrl_e   alu_ctrl;
    mul_ctrl_e   mul_ctrl;
    div_ctrl_e   div_ctrl;
    logic [2:0]  funct3;      // raw funct3 from the instruction

    modport main_mp (
        input  funct3,
        output jump, branch, result_src, mem_write, alu_src, imm_src, reg_write,
               op1_pc, jalr, rs1_used, rs2_used, mul_en, div_en, alu_op
    );

    modport alu_mp (
        input  alu_op, funct3,
        output alu_ctrl, mul_ctrl, div_ctrl
    );

    modport cu_mp (
        output funct3
    );

    modport stage_mp (
        input jump, branch, result_src, mem_write, alu_src, imm_src, reg_write,
              op1_pc, jalr, rs1_used, rs2_used, mul_en, div_en, alu_op,
              alu_ctrl, mul_ctrl, div_ctrl, funct3
    );

endinterface

/* hw/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [riscv_pkg::xlen-1:0]       ins,       // from if/id
    input  logic [riscv_pkg::xlen-1:0]       pc,
    input  logic                             in_valid,  // low means no instruction
    input  logic                             stall,     // hold id/ex
    input  logic                             flush,     // squash into a bubble
    input  logic                             wb_we,
    input  logic [riscv_pkg::reg_addr_w-1:0] wb_rd,
    input  logic [riscv_pkg::xlen-1:0]       wb_data,

    output logic                             ex_valid,
    output logic                             ex_reg_write,
    output logic                             ex_mem_write,
    output riscv_pkg::result_src_e           ex_result_src,
    output riscv_pkg::alu_ctrl_e             ex_alu_ctrl,
    output logic                             ex_alu_src,
    output logic                             ex_op1_pc,
    output logic                             ex_jump,
    output logic                             ex_branch,
    output logic                             ex_jalr,
    output logic [2:0]                       ex_funct3,
    output logic                             ex_mul_en,
    output logic                             ex_div_en,
    output riscv_pkg::mul_ctrl_e             ex_mul_ctrl,
    output riscv_pkg::div_ctrl_e             ex_div_ctrl,
    output logic [riscv_pkg::xlen-1:0]       ex_rd1,
    output logic [riscv_pkg::xlen-1:0]       ex_rd2,
    output logic [riscv_pkg::xlen-1:0]       ex_imm,
    output logic [riscv_pkg::xlen-1:0]       ex_pc,
    output logic [riscv_pkg::reg_addr_w-1:0] ex_rd,
    output logic [riscv_pkg::reg_addr_w-1:0] ex_rs1,
    output logic [riscv_pkg::reg_addr_w-1:0] ex_rs2,
    output logic                             ex_rs1_used,  // hazard unit compares these
    output logic                             ex_rs2_used
);
    import riscv_pkg::*;

    logic [reg_addr_w-1:0] rs1_idx;
    logic [reg_addr_w-1:0] rs2_idx;
    logic [reg_addr_w-1:0] rd_idx;
    logic [xlen-1:0]       rd1;
    logic [xlen-1:0]       rd2;
    logic [xlen-1:0]       imm;

    ctrl_if ctrl_bus ();

    assign rs1_idx = ins[19:15];
    assign rs2_idx = ins[24:20];
    assign rd_idx  = ins[11:7];

    control_unit u_cu (
        .ins  (ins),
        .ctrl (ctrl_bus)
    );

    imm_extend u_imm (
        .ins     (ins),
        .imm_src (ctrl_bus.imm_src),
        .imm     (imm)
    );

    reg_file u_rf (
        .clk   (clk),
        .reset (reset),
        .rs1   (rs1_idx),
        .rs2   (rs2_idx),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (wb_we),
        .rd    (wb_rd),
        .wd    (wb_data)
    );

    // id/ex control half where flush beats stall and invalid input loads a bubble
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_jump      <= 1'b0;
            ex_branch    <= 1'b0;
            ex_jalr      <= 1'b0;
            ex_mul_en    <= 1'b0;
            ex_div_en    <= 1'b0;
            ex_rs1_used  <= 1'b0;
            ex_rs2_used  <= 1'b0;
        end else if (!stall) begin
            ex_valid     <= in_valid;
            ex_reg_write <= in_valid & ctrl_bus.reg_write;
            ex_mem_write <= in_valid & ctrl_bus.mem_write;
            ex_jump      <= in_valid & ctrl_bus.jump;
            ex_branch    <= in_valid & ctrl_bus.branch;
            ex_jalr      <= in_valid & ctrl_bus.jalr;
            ex_mul_en    <= in_valid & ctrl_bus.mul_en;
            ex_div_en    <= in_valid & ctrl_bus.div_en;
            ex_rs1_used  <= in_valid & ctrl_bus.rs1_used;  // bubble reads no register
            ex_rs2_used  <= in_valid & ctrl_bus.rs2_used;
        end
    end

    // payload half only meaningful while ex_valid is set
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_result_src <= ctrl_bus.result_src;
            ex_alu_ctrl   <= ctrl_bus.alu_ctrl;
            ex_alu_src    <= ctrl_bus.alu_src;
            ex_op1_pc     <= ctrl_bus.op1_pc;
            ex_funct3     <= ctrl_bus.funct3;  // branch and load width select
            ex_mul_ctrl   <= ctrl_bus.mul_ctrl;
            ex_div_ctrl   <= ctrl_bus.div_ctrl;
            ex_rd1        <= rd1;
            ex_rd2        <= rd2;
            ex_imm        <= imm;
            ex_pc         <= pc;
            ex_rd         <= rd_idx;
            ex_rs1        <= rs1_idx;
            ex_rs2        <= rs2_idx;
        end
    end

endmodule

/* hw/imm_extend.sv */
`timescale 1ns/1ps

module imm_extend (
    input  logic [riscv_pkg::xlen-1:0] ins,
    input  riscv_pkg::imm_src_e        imm_src,  // format from the main decoder
    output logic [riscv_pkg::xlen-1:0] imm
);
    import riscv_pkg::*;

    always_comb begin
        case (imm_src)
            imm_i:   imm = {{20{ins[31]}}, ins[31:20]};
            imm_s:   imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};               // split offset
            imm_b:   imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_u:   imm = {ins[31:12], 12'b0};                                  // no extension
            imm_j:   imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

/* hw/main_decoder.sv */
`timescale 1ns/1ps

module main_decoder (
    input  riscv_pkg::opcode_e opcode,  // instruction bits 6:0
    input  logic [6:0]         funct7,  // instruction bits 31:25
    ctrl_if.main_mp            ctrl
);
    import riscv_pkg::*;

    always_comb begin
        ctrl.jump       = 1'b0;  // safe defaults cover unknown opcodes
        ctrl.branch     = 1'b0;
        ctrl.result_src = res_alu;
        ctrl.mem_write  = 1'b0;
        ctrl.alu_src    = 1'b0;
        ctrl.imm_src    = imm_i;
        ctrl.reg_write  = 1'b0;
        ctrl.op1_pc     = 1'b0;
        ctrl.jalr       = 1'b0;
        ctrl.rs1_used   = 1'b0;
        ctrl.rs2_used   = 1'b0;
        ctrl.mul_en     = 1'b0;
        ctrl.div_en     = 1'b0;
        ctrl.alu_op     = aluop_add;

        case (opcode)
            op_lui: begin
                ctrl.reg_write = 1'b1;
                ctrl.imm_src   = imm_u;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = aluop_lui;  // alu forwards the immediate
            end
            op_auipc: begin
                ctrl.reg_write = 1'b1;
                ctrl.imm_src   = imm_u;
                ctrl.alu_src   = 1'b1;
                ctrl.op1_pc    = 1'b1;  // pc + upper immediate
            end
            op_jal: begin
                ctrl.jump       = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = res_pc4;  // link address
                ctrl.imm_src    = imm_j;
                ctrl.alu_src    = 1'b1;
            end
            op_jalr: begin
                ctrl.jump       = 1'b1;
                ctrl.jalr       = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = res_pc4;
                ctrl.alu_src    = 1'b1;  // rs1 + imm target
                ctrl.rs1_used   = 1'b1;
            end
            op_branch: begin
                ctrl.branch   = 1'b1;
                ctrl.imm_src  = imm_b;
                ctrl.alu_op   = aluop_branch;
                ctrl.rs1_used = 1'b1;
                ctrl.rs2_used = 1'b1;
            end
            op_load: begin
                ctrl.reg_write  = 1'b1;
                ctrl.result_src = res_mem;
                ctrl.alu_src    = 1'b1;  // base + offset
                ctrl.rs1_used   = 1'b1;
            end
            op_store: begin
                ctrl.mem_write = 1'b1;
                ctrl.imm_src   = imm_s;
                ctrl.alu_src   = 1'b1;
                ctrl.rs1_used  = 1'b1;
                ctrl.rs2_used  = 1'b1;  // store data
            end
            op_imm: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = aluop_itype;
                ctrl.rs1_used  = 1'b1;
            end
            op_reg: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = aluop_rtype;
                ctrl.rs1_used  = 1'b1;
                ctrl.rs2_used  = 1'b1;
                if (funct7 == 7'b0000001) begin  // m extension
                    ctrl.mul_en = ~ctrl.funct3[2];
                    ctrl.div_en = ctrl.funct3[2];
                end
            end
            default: ;  // everything stays off
        endcase
    end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [riscv_pkg::reg_addr_w-1:0] rs1,
    input  logic [riscv_pkg::reg_addr_w-1:0] rs2,
    output logic [riscv_pkg::xlen-1:0]       rd1,
    output logic [riscv_pkg::xlen-1:0]       rd2,
    input  logic                             we,  // writeback enable
    input  logic [riscv_pkg::reg_addr_w-1:0] rd,
    input  logic [riscv_pkg::xlen-1:0]       wd
);
    import riscv_pkg::*;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // x0 never written
            regs[rd] <= wd;
        end
    end

    // bypass lets decode see a result written back in the same cycle
    assign rd1 = (rs1 == '0) ? '0 : (we && rd == rs1) ? wd : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : (we && rd == rs2) ? wd : regs[rs2];

endmodule

/* hw/riscv_pkg.sv */
package riscv_pkg;

    localparam int xlen       = 32;  // data path width
    localparam int reg_addr_w = 5;   // register index width
    localparam int num_regs   = 32;  // architectural registers

    // rv32 base opcodes handled by this stage
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        aluop_add    = 3'd0,  // address and link arithmetic
        aluop_branch = 3'd1,  // compare by subtraction
        aluop_rtype  = 3'd2,
        aluop_itype  = 3'd3,
        aluop_lui    = 3'd4   // immediate passes straight through
    } alu_op_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10
    } alu_ctrl_e;

    // values follow funct3[1:0] of the m extension
    typedef enum logic [1:0] {
        mul_lo  = 2'd0,
        mul_h   = 2'd1,
        mul_hsu = 2'd2,
        mul_hu  = 2'd3
    } mul_ctrl_e;

    typedef enum logic [1:0] {
        div_s = 2'd0,
        div_u = 2'd1,
        rem_s = 2'd2,
        rem_u = 2'd3
    } div_ctrl_e;

    typedef enum logic [1:0] {
        res_alu = 2'd0,  // alu result to rd
        res_mem = 2'd1,  // load data to rd
        res_pc4 = 2'd2   // return address to rd
    } result_src_e;

    typedef enum logic [2:0] {
        imm_i = 3'd0,
        imm_s = 3'd1,
        imm_b = 3'd2,
        imm_u = 3'd3,
        imm_j = 3'd4
    } imm_src_e;

endpackage

/* sim/decode_stage_asserts.sv */
`timescale 1ns/1ps

module decode_stage_asserts (
    input logic        clk,
    input logic        reset,
    input logic        stall,
    input logic        flush,
    input logic        ex_valid,
    input logic        ex_reg_write,
    input logic        ex_mem_write,
    input logic        ex_jump,
    input logic        ex_branch,
    input logic        ex_jalr,
    input logic        ex_mul_en,
    input logic        ex_div_en,
    input logic [31:0] ex_rd1,
    input logic [31:0] ex_imm,
    input logic [31:0] ex_pc,
    input logic [4:0]  ex_rd
);
    int unsigned fails = 0;  // assertion failures so far

    // reset or flush leaves a bubble in id/ex
    bubble_after_squash: assert property (@(posedge clk)
        (reset || flush) |=> !(ex_valid || ex_reg_write || ex_mem_write || ex_jump ||
                               ex_branch || ex_jalr || ex_mul_en || ex_div_en))
        else begin
            $error("id/ex holds live enables after reset or flush");
            fails++;
        end

    mul_div_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ex_mul_en && ex_div_en))
        else begin
            $error("multiply and divide enabled together");
            fails++;
        end

    hold_on_stall: assert property (@(posedge clk) disable iff (reset)
        (stall && !flush) |=> $stable(ex_valid) && $stable(ex_reg_write) &&
                              $stable(ex_rd1) && $stable(ex_imm) && $stable(ex_pc) &&
                              $stable(ex_rd))
        else begin
            $error("id/ex changed while stalled");
            fails++;
        end

endmodule

bind decode_stage decode_stage_asserts u_asserts (.*);

/* sim/decode_stage_tb.sv */
`timescale 1ns/1ps

module decode_stage_tb;
    import riscv_pkg::*;

    localparam int max_cycles = 320;  // tests run roughly 155 cycles

    logic        clk;
    logic        reset;
    logic [31:0] ins;
    logic [31:0] pc;
    logic        in_valid;
    logic        stall;
    logic        flush;
    logic        wb_we;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        ex_valid, ex_reg_write, ex_mem_write, ex_alu_src, ex_op1_pc;
    logic        ex_jump, ex_branch, ex_jalr, ex_mul_en, ex_div_en;
    logic        ex_rs1_used, ex_rs2_used;
    result_src_e ex_result_src;
    alu_ctrl_e   ex_alu_ctrl;
    mul_ctrl_e   ex_mul_ctrl;
    div_ctrl_e   ex_div_ctrl;
    logic [2:0]  ex_funct3;
    logic [31:0] ex_rd1, ex_rd2, ex_imm, ex_pc;
    logic [4:0]  ex_rd, ex_rs1, ex_rs2;
    logic [31:0] shadow [32];  // expected register contents
    int          errors = 0;
    int          cycles = 0;

    decode_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bubble(input string name);
        check(name, 32'({ex_valid, ex_reg_write, ex_mem_write, ex_jump, ex_branch, ex_jalr,
                         ex_mul_en, ex_div_en}), 32'd0);
    endtask

    // rv32 encodings, built field by field from the isa layout
    function automatic logic [31:0] r_enc(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] i_enc(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_enc(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_enc(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] u_enc(input logic [31:0] imm, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm[31:12], rd, op};
    endfunction

    function automatic logic [31:0] j_enc(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // one cycle: drive on the falling edge, sample just after the rising edge
    task automatic step(input logic [31:0] i, input logic v, input logic st, input logic fl,
                        input logic we, input logic [4:0] wrd, input logic [31:0] wdat);
        @(negedge clk);
        ins      = i;
        pc       = pc + 32'd4;
        in_valid = v;
        stall    = st;
        flush    = fl;
        wb_we    = we;
        wb_rd    = wrd;
        wb_data  = wdat;
        @(posedge clk);
        #1;
        if (we && wrd != 5'd0) shadow[wrd] = wdat;  // x0 stays zero
    endtask

    task automatic decode(input logic [31:0] i);
        step(i, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        reset    = 1'b1;
        in_valid = 1'b0;
        wb_we    = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        foreach (shadow[r]) shadow[r] = '0;
    endtask

    task automatic fill_regs();
        for (int r = 0; r < 32; r++) begin
            step(32'd0, 1'b0, 1'b0, 1'b0, 1'b1, r[4:0], $urandom);  // x0 write too
        end
    endtask

    task automatic read_regs();
        for (int r = 0; r < 32; r += 2) begin
            decode(r_enc(7'h00, 5'(r + 1), r[4:0], 3'b000, 5'd1));
            check("ex_rd1", ex_rd1, shadow[r[4:0]]);
            check("ex_rd2", ex_rd2, shadow[5'(r + 1)]);
        end
    endtask

    task automatic reg_file_rw();
        logic [31:0] v;
        fill_regs();
        read_regs();
        v = $urandom;
        step(r_enc(7'h00, 5'd9, 5'd17, 3'b000, 5'd1), 1'b1, 1'b0, 1'b0, 1'b1, 5'd17, v);
        check("ex_rd1 bypass", ex_rd1, v);
        step(r_enc(7'h00, 5'd0, 5'd0, 3'b000, 5'd1), 1'b1, 1'b0, 1'b0, 1'b1, 5'd0, v);
        check("ex_rd1 x0", ex_rd1, 32'd0);  // no bypass on x0
        check("ex_rd2 x0", ex_rd2, 32'd0);
        apply_reset();
        check_bubble("bubble after reset");
        read_regs();  // all zero now
        fill_regs();
    endtask

    task automatic rtype_case(input logic [6:0] f7, input logic [2:0] f3,
                              input alu_ctrl_e exp_ctrl);
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        rs1 = 5'($urandom_range(31, 1));
        rs2 = 5'($urandom_range(31, 1));
        rd  = 5'($urandom_range(31, 1));
        decode(r_enc(f7, rs2, rs1, f3, rd));
        check("ex_alu_ctrl", 32'(ex_alu_ctrl), 32'(exp_ctrl));
        check("ex_reg_write", 32'(ex_reg_write), 32'd1);
        check("ex_rd1", ex_rd1, shadow[rs1]);
        check("ex_rd2", ex_rd2, shadow[rs2]);
        check("ex_rd", 32'(ex_rd), 32'(rd));
        check("ex_rs1", 32'(ex_rs1), 32'(rs1));  // numbers handed to the hazard unit
        check("ex_rs2", 32'(ex_rs2), 32'(rs2));
        check("ex_mul_en/div_en", 32'({ex_mul_en, ex_div_en}), 32'd0);
    endtask

    task automatic rtype_and_m_ops();
        logic [2:0] f3;
        rtype_case(7'h00, 3'b000, alu_add);
        rtype_case(7'h20, 3'b000, alu_sub);
        rtype_case(7'h00, 3'b001, alu_sll);
        rtype_case(7'h00, 3'b010, alu_slt);
        rtype_case(7'h00, 3'b011, alu_sltu);
        rtype_case(7'h00, 3'b100, alu_xor);
        rtype_case(7'h00, 3'b101, alu_srl);
        rtype_case(7'h20, 3'b101, alu_sra);
        rtype_case(7'h00, 3'b110, alu_or);
        rtype_case(7'h00, 3'b111, alu_and);
        for (int f = 0; f < 8; f++) begin
            f3 = f[2:0];
            decode(r_enc(7'h01, 5'd2, 5'd3, f3, 5'd4));
            check("ex_mul_en", 32'(ex_mul_en), 32'(!f3[2]));  // mul* has funct3[2] clear
            check("ex_div_en", 32'(ex_div_en), 32'(f3[2]));
            check("ex_reg_write", 32'(ex_reg_write), 32'd1);
            if (f3[2]) begin
                check("ex_div_ctrl", 32'(ex_div_ctrl), 32'(f3[1:0]));
            end else begin
                check("ex_mul_ctrl", 32'(ex_mul_ctrl), 32'(f3[1:0]));
            end
        end
    endtask

    // flags are reg_write mem_write alu_src op1_pc jump jalr branch rs1_used rs2_used
    task automatic format_case(input logic [31:0] i, input logic [31:0] exp_imm,
                               input result_src_e exp_res, input logic [8:0] exp_flags);
        decode(i);
        check("ex_imm", ex_imm, exp_imm);
        check("ex_result_src", 32'(ex_result_src), 32'(exp_res));
        check("ex_flags", 32'({ex_reg_write, ex_mem_write, ex_alu_src, ex_op1_pc, ex_jump,
                               ex_jalr, ex_branch, ex_rs1_used, ex_rs2_used}), 32'(exp_flags));
        check("ex_funct3", 32'(ex_funct3), 32'(i[14:12]));
        check("ex_pc", ex_pc, pc);
    endtask

    task automatic immediate_formats();
        format_case(i_enc(12'hff4, 5'd3, 3'b010, 5'd5, op_load), 32'hffff_fff4, res_mem,
                    9'b101000010);
        format_case(s_enc(12'h7fc, 5'd7, 5'd2, 3'b010), 32'h0000_07fc, res_alu, 9'b011000011);
        format_case(b_enc(13'h1004, 5'd6, 5'd5, 3'b001), 32'hffff_f004, res_alu, 9'b000000111);
        check("branch ex_alu_ctrl", 32'(ex_alu_ctrl), 32'(alu_sub));
        format_case(j_enc(21'h100f12, 5'd1), 32'hfff0_0f12, res_pc4, 9'b101010000);
        format_case(i_enc(12'hffc, 5'd9, 3'b000, 5'd1, op_jalr), 32'hffff_fffc, res_pc4,
                    9'b101011010);
        format_case(u_enc(32'habcd_e000, 5'd10, op_lui), 32'habcd_e000, res_alu, 9'b101000000);
        check("lui ex_alu_ctrl", 32'(ex_alu_ctrl), 32'(alu_pass_b));
        format_case(u_enc(32'h1234_5000, 5'd11, op_auipc), 32'h1234_5000, res_alu,
                    9'b101100000);
        check("auipc ex_alu_ctrl", 32'(ex_alu_ctrl), 32'(alu_add));
        format_case(i_enc({7'b0100000, 5'd7}, 5'd12, 3'b101, 5'd13, op_imm), 32'h0000_0407,
                    res_alu, 9'b101000010);
        check("srai ex_alu_ctrl", 32'(ex_alu_ctrl), 32'(alu_sra));
        decode(i_enc(12'h400, 5'd1, 3'b000, 5'd2, op_imm));  // bit 30 set, still an add
        check("addi ex_alu_ctrl", 32'(ex_alu_ctrl), 32'(alu_add));
    endtask

    task automatic usage_case(input logic [31:0] i, input logic [1:0] exp_used);
        decode(i);
        check("ex_rs1_used/rs2_used", 32'({ex_rs1_used, ex_rs2_used}), 32'(exp_used));
    endtask

    task automatic source_usage();
        usage_case(u_enc(32'hfff8_f000, 5'd1, op_lui), 2'b00);  // rs fields nonzero
        usage_case(u_enc(32'hfff8_f000, 5'd1, op_auipc), 2'b00);
        usage_case(j_enc(21'h0ff8f0, 5'd1), 2'b00);
        usage_case(i_enc(12'h001, 5'd2, 3'b000, 5'd3, op_imm), 2'b10);
        usage_case(i_enc(12'h010, 5'd2, 3'b010, 5'd3, op_load), 2'b10);
        usage_case(s_enc(12'h010, 5'd4, 5'd2, 3'b010), 2'b11);
        usage_case(b_enc(13'h0010, 5'd4, 5'd2, 3'b000), 2'b11);
        usage_case(r_enc(7'h00, 5'd4, 5'd2, 3'b000, 5'd3), 2'b11);
    endtask

    task automatic pipeline_hold_flush();
        logic [31:0] held_rd1;
        logic [31:0] held_imm;
        logic [31:0] held_pc;
        decode(i_enc(12'h123, 5'd4, 3'b000, 5'd6, op_imm));
        held_rd1 = ex_rd1;
        held_imm = ex_imm;
        held_pc  = ex_pc;
        repeat (2) begin
            // a new store and a write to the held source must not leak in
            step(s_enc(12'h7f0, 5'd8, 5'd9, 3'b010), 1'b1, 1'b1, 1'b0, 1'b1, 5'd4, $urandom);
            check("stalled ex_valid", 32'(ex_valid), 32'd1);
            check("stalled ex_mem_write", 32'(ex_mem_write), 32'd0);
            check("stalled ex_rd1", ex_rd1, held_rd1);
            check("stalled ex_imm", ex_imm, held_imm);
            check("stalled ex_pc", ex_pc, held_pc);
            check("stalled ex_rd", 32'(ex_rd), 32'd6);
        end
        step(r_enc(7'h00, 5'd1, 5'd2, 3'b000, 5'd3), 1'b1, 1'b1, 1'b1, 1'b0, 5'd0, 32'd0);
        check_bubble("flush over stall");
        step(r_enc(7'h00, 5'd1, 5'd2, 3'b000, 5'd3), 1'b0, 1'b0, 1'b0, 1'b0, 5'd0, 32'd0);
        check_bubble("in_valid low");
        step(r_enc(7'h00, 5'd1, 5'd2, 3'b000, 5'd3), 1'b1, 1'b0, 1'b1, 1'b0, 5'd0, 32'd0);
        check_bubble("flush");
        decode(r_enc(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
        check("ex_valid after flush", 32'(ex_valid), 32'd1);
    endtask

    task automatic unknown_opcode();
        logic [31:0] bad [3];
        bad[0] = 32'hffff_ffff;  // opcode 1111111
        bad[1] = 32'h0000_0000;
        bad[2] = 32'h0000_0073;  // ecall, not decoded here
        foreach (bad[k]) begin
            decode(bad[k]);
            check("unknown ex_valid", 32'(ex_valid), 32'd1);
            check("unknown enables", 32'({ex_reg_write, ex_mem_write, ex_jump, ex_branch,
                                          ex_jalr, ex_mul_en, ex_div_en}), 32'd0);
        end
    endtask

    initial begin
        void'($urandom(90));
        reset    = 1'b1;
        ins      = '0;
        pc       = '0;
        in_valid = 1'b0;
        stall    = 1'b0;
        flush    = 1'b0;
        wb_we    = 1'b0;
        wb_rd    = '0;
        wb_data  = '0;
        foreach (shadow[r]) shadow[r] = '0;
        apply_reset();
        reg_file_rw();
        rtype_and_m_ops();
        immediate_formats();
        source_usage();
        pipeline_hold_flush();
        unknown_opcode();
        errors = errors + int'(uut.u_asserts.fails);
        $display("run done: %0d errors after %0d cycles", errors, cycles);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
